//--- verilog/fir_dsp_pkg.sv
`default_nettype none

// Shared widths, pipeline offsets and bundled operand types for the FIR tap
package fir_dsp_pkg;

    // Sample inputs A and D
    localparam int SAMPLE_W = 26;

    // Pre-adder keeps one guard bit so D + A never overflows
    localparam int PREADD_W = SAMPLE_W + 1;

    // Tap coefficient
    localparam int COEFF_W = 18;

    // Full signed product of the pre-adder sum and the coefficient
    localparam int PROD_W = PREADD_W + COEFF_W;

    // Post-adder, C operand, cascade in and out
    localparam int ACC_W = 48;

    // Pipeline offsets, counted in edges from the edge that samples A and D

    // Edge at which c_i is captured
    localparam int C_OFFSET = 2;

    // Edge at which pcin_i enters the post-adder
    localparam int PCIN_OFFSET = 3;

    // Edge at which the result lands in the output register
    localparam int P_LATENCY = 3;

    // The two samples that meet in the pre-adder
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] a;
        logic signed [SAMPLE_W-1:0] d;
    } sample_t;

    // Operands of the post-adder besides the product
    typedef struct packed {
        logic signed [ACC_W-1:0] c;
        logic signed [ACC_W-1:0] pcin;
    } acc_in_t;

endpackage

`default_nettype wire

//--- verilog/fir_coeff_regs.sv
`timescale 1ns/1ns
`default_nettype none

// Two-stage coefficient storage for one FIR tap
//
// load_i captures b_i into the staging register. update_i then moves the
// staged word into the active register that feeds the multiplier. The
// staging register also leaves the tap as bcout_o, so a row of taps can
// shift a new coefficient set through their staging registers and then
// switch all of them over with one update
module fir_coeff_regs (
    input  wire                               clk_i,
    input  wire                               rst_n_i,
    input  wire [fir_dsp_pkg::COEFF_W-1:0]    b_i,
    input  wire                               load_i,
    input  wire                               update_i,
    output logic [fir_dsp_pkg::COEFF_W-1:0]   coeff_o,
    output logic [fir_dsp_pkg::COEFF_W-1:0]   bcout_o
);

    // Staging register, written by load_i
    logic [fir_dsp_pkg::COEFF_W-1:0] stage_q;

    // Active register, seen by the multiplier
    logic [fir_dsp_pkg::COEFF_W-1:0] active_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage_q <= '0;
        end else if (load_i) begin
            stage_q <= b_i;
        end
    end

    // With load and update at the same edge the active register takes
    // the staging value from before that edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= '0;
        end else if (update_i) begin
            active_q <= stage_q;
        end
    end

    assign coeff_o = active_q;

    // Cascade towards the next tap in the load chain
    assign bcout_o = stage_q;

endmodule

`default_nettype wire

//--- verilog/fir_mult_path.sv
`timescale 1ns/1ns
`default_nettype none

// Front half of the FIR tap
//
// Stage 1 registers A and D, stage 2 registers the pre-adder sum D + A,
// stage 3 registers the product with the active coefficient. The product
// leaves sign-extended to the post-adder width
module fir_mult_path (
    input  wire                               clk_i,
    input  wire                               rst_n_i,
    input  wire fir_dsp_pkg::sample_t         sample_i,
    input  wire [fir_dsp_pkg::COEFF_W-1:0]    coeff_i,
    output logic [fir_dsp_pkg::ACC_W-1:0]     prod_o
);

    localparam int EXT_W = fir_dsp_pkg::PREADD_W - fir_dsp_pkg::SAMPLE_W;
    localparam int PROD_EXT_W = fir_dsp_pkg::ACC_W - fir_dsp_pkg::PROD_W;

    // Input registers for both samples
    fir_dsp_pkg::sample_t sample_q;

    // Samples widened to the pre-adder width
    logic signed [fir_dsp_pkg::PREADD_W-1:0] a_ext;
    logic signed [fir_dsp_pkg::PREADD_W-1:0] d_ext;

    // Pre-adder
    logic signed [fir_dsp_pkg::PREADD_W-1:0] preadd_d;
    logic signed [fir_dsp_pkg::PREADD_W-1:0] preadd_q;

    // Multiplier
    logic signed [fir_dsp_pkg::COEFF_W-1:0] coeff_s;
    logic signed [fir_dsp_pkg::PROD_W-1:0]  prod_d;
    logic signed [fir_dsp_pkg::PROD_W-1:0]  prod_q;

    // Stage 1
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sample_q <= '0;
        end else begin
            sample_q <= sample_i;
        end
    end

    assign a_ext = {{EXT_W{sample_q.a[fir_dsp_pkg::SAMPLE_W-1]}}, sample_q.a};
    assign d_ext = {{EXT_W{sample_q.d[fir_dsp_pkg::SAMPLE_W-1]}}, sample_q.d};

    // The guard bit keeps the sum exact for any pair of samples
    assign preadd_d = d_ext + a_ext;

    // Stage 2
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            preadd_q <= '0;
        end else begin
            preadd_q <= preadd_d;
        end
    end

    // Both operands signed, so the product is a full signed result
    assign coeff_s = $signed(coeff_i);
    assign prod_d  = preadd_q * coeff_s;

    // Stage 3 uses the coefficient that was active over the previous cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prod_q <= '0;
        end else begin
            prod_q <= prod_d;
        end
    end

    assign prod_o = {{PROD_EXT_W{prod_q[fir_dsp_pkg::PROD_W-1]}}, prod_q};

endmodule

`default_nettype wire

//--- verilog/fir_post_adder.sv
`timescale 1ns/1ns
`default_nettype none

// Back half of the FIR tap
//
// C is registered one edge before the output register so that it lines
// up with the product. PCIN is not registered, since the previous tap
// already presents it from its own output register
module fir_post_adder (
    input  wire                               clk_i,
    input  wire                               rst_n_i,
    input  wire [fir_dsp_pkg::ACC_W-1:0]      prod_i,
    input  wire fir_dsp_pkg::acc_in_t         acc_i,
    output logic [fir_dsp_pkg::ACC_W-1:0]     p_o
);

    // C input register
    logic [fir_dsp_pkg::ACC_W-1:0] c_q;

    // Three-operand sum and output register
    logic [fir_dsp_pkg::ACC_W-1:0] sum_d;
    logic [fir_dsp_pkg::ACC_W-1:0] p_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            c_q <= '0;
        end else begin
            c_q <= acc_i.c;
        end
    end

    // Two's complement wraps, so one unsigned add covers the signed case
    assign sum_d = prod_i + c_q + acc_i.pcin;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            p_q <= '0;
        end else begin
            p_q <= sum_d;
        end
    end

    assign p_o = p_q;

endmodule

`default_nettype wire

//--- verilog/fir_dsp_core.sv
`timescale 1ns/1ns
`default_nettype none

// FIR tap core
//
// Computes P = (D + A) * B + C + PCIN in a fixed pipeline
//   edge n    A and D registered
//   edge n+1  pre-adder sum registered
//   edge n+2  product registered, C registered
//   edge n+3  sum with PCIN registered into P
// The coefficient B is loaded in two steps through load_i and update_i,
// and the staging register is passed on as bcout_o for chained loading
module fir_dsp_core (
    input  wire                               clk_i,
    input  wire                               rst_n_i,
    input  wire fir_dsp_pkg::sample_t         sample_i,
    input  wire [fir_dsp_pkg::COEFF_W-1:0]    b_i,
    input  wire                               load_i,
    input  wire                               update_i,
    input  wire fir_dsp_pkg::acc_in_t         acc_i,
    output logic [fir_dsp_pkg::ACC_W-1:0]     p_o,
    output logic [fir_dsp_pkg::ACC_W-1:0]     pcout_o,
    output logic [fir_dsp_pkg::COEFF_W-1:0]   bcout_o
);

    // Active coefficient into the multiplier
    logic [fir_dsp_pkg::COEFF_W-1:0] coeff;

    // Registered product already at the post-adder width
    logic [fir_dsp_pkg::ACC_W-1:0] prod;

    // Output register of the post-adder
    logic [fir_dsp_pkg::ACC_W-1:0] p;

    fir_coeff_regs u_coeff_regs (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .b_i      (b_i),
        .load_i   (load_i),
        .update_i (update_i),
        .coeff_o  (coeff),
        .bcout_o  (bcout_o)
    );

    fir_mult_path u_mult_path (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .sample_i (sample_i),
        .coeff_i  (coeff),
        .prod_o   (prod)
    );

    fir_post_adder u_post_adder (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .prod_i   (prod),
        .acc_i    (acc_i),
        .p_o      (p)
    );

    // The cascade output carries the same word as P
    assign p_o     = p;
    assign pcout_o = p;

endmodule

`default_nettype wire

//--- verification/fir_dsp_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fir_dsp_core_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 3;
    localparam int STREAM_LEN    = 40;
    localparam int STREAM_CYCLES = STREAM_LEN + 2;
    localparam int STAGE_CYCLES  = 12;
    localparam int CHANGE_CYCLES = 37;
    localparam int EDGE_CYCLES   = 16;
    localparam int DRAIN_CYCLES  = fir_dsp_pkg::P_LATENCY + 1;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 1 + STREAM_CYCLES + STAGE_CYCLES
                                 + CHANGE_CYCLES + EDGE_CYCLES + DRAIN_CYCLES + 2;
    localparam int WATCHDOG_NS   = (TOTAL_CYCLES + 50) * CLK_PERIOD;
    localparam int HIST_LEN      = TOTAL_CYCLES + 64;

    // Extreme operand values
    localparam logic [fir_dsp_pkg::SAMPLE_W-1:0] S_MIN = {1'b1, {(fir_dsp_pkg::SAMPLE_W-1){1'b0}}};
    localparam logic [fir_dsp_pkg::SAMPLE_W-1:0] S_MAX = ~S_MIN;
    localparam logic [fir_dsp_pkg::COEFF_W-1:0]  B_MIN = {1'b1, {(fir_dsp_pkg::COEFF_W-1){1'b0}}};
    localparam logic [fir_dsp_pkg::COEFF_W-1:0]  B_MAX = ~B_MIN;
    localparam logic [fir_dsp_pkg::ACC_W-1:0]    C_MIN = {1'b1, {(fir_dsp_pkg::ACC_W-1){1'b0}}};
    localparam logic [fir_dsp_pkg::ACC_W-1:0]    C_MAX = ~C_MIN;

    logic clk_i = 1'b0;
    logic rst_n_i;
    fir_dsp_pkg::sample_t sample_i;
    logic [fir_dsp_pkg::COEFF_W-1:0] b_i;
    logic load_i;
    logic update_i;
    fir_dsp_pkg::acc_in_t acc_i;
    logic [fir_dsp_pkg::ACC_W-1:0] p_o;
    logic [fir_dsp_pkg::ACC_W-1:0] pcout_o;
    logic [fir_dsp_pkg::COEFF_W-1:0] bcout_o;

    integer seed = 32'h737b_52b3;
    int edge_cnt = 0;
    int error_cnt = 0;

    // Inputs as sampled by each numbered rising edge
    fir_dsp_pkg::sample_t hist_s [0:HIST_LEN-1];
    fir_dsp_pkg::acc_in_t hist_acc [0:HIST_LEN-1];
    logic [fir_dsp_pkg::COEFF_W-1:0] hist_b [0:HIST_LEN-1];
    logic hist_ld [0:HIST_LEN-1];
    logic hist_upd [0:HIST_LEN-1];

    // Coefficient model and the active value after each edge
    logic [fir_dsp_pkg::COEFF_W-1:0] stage_m = '0;
    logic [fir_dsp_pkg::COEFF_W-1:0] active_m = '0;
    logic [fir_dsp_pkg::COEFF_W-1:0] act_hist [0:HIST_LEN-1];

    fir_dsp_core dut0 (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .sample_i (sample_i),
        .b_i      (b_i),
        .load_i   (load_i),
        .update_i (update_i),
        .acc_i    (acc_i),
        .p_o      (p_o),
        .pcout_o  (pcout_o),
        .bcout_o  (bcout_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        edge_cnt <= edge_cnt + 1;
    end

    // Expected tap output (d + a) * b + c + pcin over signed operands wrapped to 48 bits
    function automatic logic [fir_dsp_pkg::ACC_W-1:0] ref_tap(
        input logic signed [fir_dsp_pkg::SAMPLE_W-1:0] a,
        input logic signed [fir_dsp_pkg::SAMPLE_W-1:0] d,
        input logic signed [fir_dsp_pkg::COEFF_W-1:0]  b,
        input logic signed [fir_dsp_pkg::ACC_W-1:0]    c,
        input logic signed [fir_dsp_pkg::ACC_W-1:0]    pcin
    );
        longint sum;
        sum = (longint'(d) + longint'(a)) * longint'(b);
        sum = sum + longint'(c) + longint'(pcin);
        return sum[fir_dsp_pkg::ACC_W-1:0];
    endfunction

    task automatic check_value(
        input string                        name,
        input logic [fir_dsp_pkg::ACC_W-1:0] exp_v,
        input logic [fir_dsp_pkg::ACC_W-1:0] act_v
    );
        assert (act_v === exp_v) else begin
            error_cnt++;
            $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, exp_v, act_v);
            $display("** FAIL **");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic fir_dsp_pkg::sample_t rand_sample();
        fir_dsp_pkg::sample_t s;
        s.a = $random(seed);
        s.d = $random(seed);
        return s;
    endfunction

    function automatic fir_dsp_pkg::acc_in_t rand_acc();
        fir_dsp_pkg::acc_in_t v;
        v.c    = {$random(seed), $random(seed)};
        v.pcin = {$random(seed), $random(seed)};
        return v;
    endfunction

    function automatic logic [fir_dsp_pkg::COEFF_W-1:0] rand_coeff();
        return $random(seed);
    endfunction

    // One cycle of inputs applied just after a rising edge and taken by the next one
    task automatic drive_cycle(
        input fir_dsp_pkg::sample_t          s,
        input logic [fir_dsp_pkg::COEFF_W-1:0] b,
        input logic                          ld,
        input logic                          upd,
        input fir_dsp_pkg::acc_in_t          acc
    );
        int k;
        @(posedge clk_i);
        #1;
        sample_i = s;
        b_i      = b;
        load_i   = ld;
        update_i = upd;
        acc_i    = acc;
        k = edge_cnt + 1;
        hist_s[k]   = s;
        hist_b[k]   = b;
        hist_ld[k]  = ld;
        hist_upd[k] = upd;
        hist_acc[k] = acc;
    endtask

    task automatic coeff_cycle(
        input logic [fir_dsp_pkg::COEFF_W-1:0] b,
        input logic                          ld,
        input logic                          upd
    );
        drive_cycle(rand_sample(), b, ld, upd, rand_acc());
    endtask

    // b_i carries noise here that must be ignored without load_i
    task automatic random_cycles(input int count);
        repeat (count) coeff_cycle(rand_coeff(), 1'b0, 1'b0);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) drive_cycle('0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic extreme_cycle(
        input logic [fir_dsp_pkg::SAMPLE_W-1:0] a,
        input logic [fir_dsp_pkg::SAMPLE_W-1:0] d,
        input logic [fir_dsp_pkg::ACC_W-1:0]    c,
        input logic [fir_dsp_pkg::ACC_W-1:0]    pcin
    );
        fir_dsp_pkg::sample_t s;
        fir_dsp_pkg::acc_in_t acc;
        s.a      = a;
        s.d      = d;
        acc.c    = c;
        acc.pcin = pcin;
        drive_cycle(s, '0, 1'b0, 1'b0, acc);
    endtask

    // Six samples at the corners of the operand ranges
    task automatic extreme_block();
        extreme_cycle(S_MIN, S_MIN, C_MAX, C_MAX);
        extreme_cycle(S_MIN, S_MIN, C_MIN, C_MIN);
        extreme_cycle(S_MAX, S_MAX, C_MAX, C_MAX);
        extreme_cycle(S_MAX, S_MIN, C_MIN, C_MAX);
        extreme_cycle(S_MAX, S_MAX, C_MIN, C_MIN);
        extreme_cycle('0, S_MIN, C_MAX, C_MIN);
    endtask

    // Reference model and comparison half a cycle after every rising edge
    always @(negedge clk_i) begin
        int k;
        int n;
        logic [fir_dsp_pkg::ACC_W-1:0] exp_p;
        k = edge_cnt;
        if (k > 0) begin
            // Update reads the staging value from before this edge
            if (hist_upd[k]) begin
                active_m = stage_m;
            end
            if (hist_ld[k]) begin
                stage_m = hist_b[k];
            end
            act_hist[k] = active_m;
            if (k >= fir_dsp_pkg::P_LATENCY) begin
                n = k - fir_dsp_pkg::P_LATENCY;
                exp_p = ref_tap(hist_s[n].a, hist_s[n].d, act_hist[n+1],
                                hist_acc[n+fir_dsp_pkg::C_OFFSET].c,
                                hist_acc[n+fir_dsp_pkg::PCIN_OFFSET].pcin);
            end else begin
                exp_p = '0;
            end
            check_value("p_o", exp_p, p_o);
            check_value("pcout_o", exp_p, pcout_o);
            check_value("bcout_o", {{(fir_dsp_pkg::ACC_W-fir_dsp_pkg::COEFF_W){1'b0}}, stage_m},
                        {{(fir_dsp_pkg::ACC_W-fir_dsp_pkg::COEFF_W){1'b0}}, bcout_o});
        end
    end

    initial begin
        logic [fir_dsp_pkg::COEFF_W-1:0] b_new;
        logic [fir_dsp_pkg::COEFF_W-1:0] b_next;
        rst_n_i  = 1'b0;
        sample_i = '0;
        b_i      = '0;
        load_i   = 1'b0;
        update_i = 1'b0;
        acc_i    = '0;
        for (int i = 0; i < HIST_LEN; i++) begin
            hist_s[i]   = '0;
            hist_acc[i] = '0;
            hist_b[i]   = '0;
            hist_ld[i]  = 1'b0;
            hist_upd[i] = 1'b0;
            act_hist[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Outputs cleared by reset
        @(negedge clk_i);
        check_value("p_o", '0, p_o);
        check_value("pcout_o", '0, pcout_o);
        check_value("bcout_o", '0, {{(fir_dsp_pkg::ACC_W-fir_dsp_pkg::COEFF_W){1'b0}}, bcout_o});

        // Load and update one coefficient before a random stream
        coeff_cycle(rand_coeff(), 1'b1, 1'b0);
        coeff_cycle(rand_coeff(), 1'b0, 1'b1);
        random_cycles(STREAM_LEN);

        // Staging only while the products keep the old coefficient
        b_new = rand_coeff();
        coeff_cycle(b_new, 1'b1, 1'b0);
        random_cycles(1);
        @(negedge clk_i);
        check_value("bcout_o", {{(fir_dsp_pkg::ACC_W-fir_dsp_pkg::COEFF_W){1'b0}}, b_new},
                    {{(fir_dsp_pkg::ACC_W-fir_dsp_pkg::COEFF_W){1'b0}}, bcout_o});
        random_cycles(10);

        // Update in the middle of the stream
        coeff_cycle(rand_coeff(), 1'b0, 1'b1);
        random_cycles(5);
        coeff_cycle(rand_coeff(), 1'b1, 1'b0);
        coeff_cycle(rand_coeff(), 1'b0, 1'b1);
        random_cycles(8);

        // Load and update together move the previously staged word
        b_new  = rand_coeff();
        b_next = rand_coeff();
        coeff_cycle(b_new, 1'b1, 1'b0);
        random_cycles(3);
        coeff_cycle(b_next, 1'b1, 1'b1);
        random_cycles(1);
        @(negedge clk_i);
        check_value("bcout_o", {{(fir_dsp_pkg::ACC_W-fir_dsp_pkg::COEFF_W){1'b0}}, b_next},
                    {{(fir_dsp_pkg::ACC_W-fir_dsp_pkg::COEFF_W){1'b0}}, bcout_o});
        random_cycles(8);
        coeff_cycle(rand_coeff(), 1'b0, 1'b1);
        random_cycles(6);

        // Extreme operands with the largest and the most negative coefficient
        coeff_cycle(B_MAX, 1'b1, 1'b0);
        coeff_cycle(rand_coeff(), 1'b0, 1'b1);
        extreme_block();
        coeff_cycle(B_MIN, 1'b1, 1'b0);
        coeff_cycle(rand_coeff(), 1'b0, 1'b1);
        extreme_block();

        // Let the last samples leave the pipeline
        idle_cycles(DRAIN_CYCLES);
        repeat (2) @(posedge clk_i);

        if (error_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- build.f
verilog/fir_dsp_pkg.sv
verilog/fir_coeff_regs.sv
verilog/fir_mult_path.sv
verilog/fir_post_adder.sv
verilog/fir_dsp_core.sv
verification/fir_dsp_core_tb.sv

//--- Bender.yml
package:
  name: fir_dsp_core

sources:
  # Package first, then the blocks, then the top level
  - verilog/fir_dsp_pkg.sv
  - verilog/fir_coeff_regs.sv
  - verilog/fir_mult_path.sv
  - verilog/fir_post_adder.sv
  - verilog/fir_dsp_core.sv

  - target: test
    files:
      - verification/fir_dsp_core_tb.sv
